//--- build.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/sync_ram.sv
verilog/dcache_ctrl.sv
verilog/way_select.sv
verilog/dcache_top.sv
bench/dcache_checker.sv
bench/tb_dcache.sv

//--- run.sh
#!/bin/bash
# build and run the dcache testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module tb_dcache -Mdir obj_dir -o sim_dcache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_dcache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    exit 1
fi
exit 0

//--- bench/tb_dcache.sv
`include "dcache_settings.svh"

module tb_dcache
    import dcache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS    = 5;
    localparam int TOTAL_REQS   = 8 + 7 + 5 + 80 + 40;
    localparam int MISS_CYCLES  = 30;   // writeback plus refill at the longest delays
    localparam int LIMIT_CYCLES = `SET_NUM + 10 + TOTAL_REQS * MISS_CYCLES;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  req_valid_i;
    logic                  req_write_i;
    logic [`ADDR_SIZE-1:0] req_addr_i;
    logic [`STRB_SIZE-1:0] req_wstrb_i;
    word_t                 req_wdata_i;
    logic                  addr_ok_o;
    logic                  data_ok_o;
    word_t                 rdata_o;
    logic                  cache_miss_o;
    logic                  rd_req_o;
    logic [`ADDR_SIZE-1:0] rd_addr_o;
    logic                  rd_rdy_i;
    logic                  ret_valid_i;
    line_t                 ret_data_i;
    logic                  wr_req_o;
    logic [`ADDR_SIZE-1:0] wr_addr_o;
    line_t                 wr_data_o;
    logic                  wr_rdy_i;
    logic                  test_end;
    logic                  idle;
    int                    tests;
    int                    failed;
    int                    errors;
    int                    seed = 47161;
    line_t                 mem [int unsigned];   // lines written back, by line address

    always #20 clk = ~clk;

    dcache_top DUT (
        .clk          (clk),
        .reset        (reset),
        .req_valid_i  (req_valid_i),
        .req_write_i  (req_write_i),
        .req_addr_i   (req_addr_i),
        .req_wstrb_i  (req_wstrb_i),
        .req_wdata_i  (req_wdata_i),
        .addr_ok_o    (addr_ok_o),
        .data_ok_o    (data_ok_o),
        .rdata_o      (rdata_o),
        .cache_miss_o (cache_miss_o),
        .rd_req_o     (rd_req_o),
        .rd_addr_o    (rd_addr_o),
        .rd_rdy_i     (rd_rdy_i),
        .ret_valid_i  (ret_valid_i),
        .ret_data_i   (ret_data_i),
        .wr_req_o     (wr_req_o),
        .wr_addr_o    (wr_addr_o),
        .wr_data_o    (wr_data_o),
        .wr_rdy_i     (wr_rdy_i)
    );

    dcache_checker u_checker (
        .clk          (clk),
        .reset        (reset),
        .req_valid_i  (req_valid_i),
        .req_write_i  (req_write_i),
        .req_addr_i   (req_addr_i),
        .req_wstrb_i  (req_wstrb_i),
        .req_wdata_i  (req_wdata_i),
        .addr_ok_i    (addr_ok_o),
        .data_ok_i    (data_ok_o),
        .rdata_i      (rdata_o),
        .cache_miss_i (cache_miss_o),
        .rd_req_i     (rd_req_o),
        .rd_addr_i    (rd_addr_o),
        .rd_rdy_i     (rd_rdy_i),
        .wr_req_i     (wr_req_o),
        .wr_addr_i    (wr_addr_o),
        .wr_data_i    (wr_data_o),
        .wr_rdy_i     (wr_rdy_i),
        .test_end_i   (test_end),
        .idle_o       (idle),
        .tests_o      (tests),
        .failed_o     (failed),
        .errors_o     (errors)
    );

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    function automatic word_t initial_word(input logic [`ADDR_SIZE-1:0] addr);
        return {~addr[15:0], addr[31:16]} ^ 32'h1357_9bdf;
    endfunction

    function automatic line_t read_line(input logic [`ADDR_SIZE-1:0] line_addr);
        line_t l;
        if (mem.exists(line_addr)) begin
            return mem[line_addr];
        end
        for (int i = 0; i < `BANK_NUM; i++) begin
            l[i] = initial_word(line_addr + `ADDR_SIZE'(4 * i));
        end
        return l;
    endfunction

    // caller sits on a falling edge, returns on the one after acceptance
    task automatic cpu_access(input logic write, input logic [`ADDR_SIZE-1:0] addr,
                              input logic [`STRB_SIZE-1:0] strb, input word_t data);
        req_valid_i = 1'b1;
        req_write_i = write;
        req_addr_i  = addr;
        req_wstrb_i = strb;
        req_wdata_i = data;
        while (!addr_ok_o) @(negedge clk);
        @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    task automatic random_burst(input int count, input int tag_span,
                                input int index_base, input int index_span);
        logic [`TAG_SIZE-1:0]   tag;
        logic [`INDEX_SIZE-1:0] index;
        word_t                  rnd;
        for (int i = 0; i < count; i++) begin
            rnd   = $random(seed);
            tag   = 20'(8 + rand_below(tag_span));
            index = 7'(index_base + rand_below(index_span));
            cpu_access(rand_below(2) == 1, {tag, index, rnd[`WORD_OFF_SIZE-1:0], 2'b00},
                       rnd[8 +: `STRB_SIZE], $random(seed));
        end
    endtask

    task automatic finish_test();
        while (!idle) @(negedge clk);
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    // line memory with random handshake delays
    initial begin : memory_model
        logic [`ADDR_SIZE-1:0] addr;
        forever begin
            @(negedge clk);
            if (rd_req_o) begin
                addr = rd_addr_o;
                repeat (rand_below(5)) @(negedge clk);
                rd_rdy_i = 1'b1;
                @(negedge clk);
                rd_rdy_i = 1'b0;
                repeat (rand_below(5)) @(negedge clk);
                ret_data_i  = read_line(addr);
                ret_valid_i = 1'b1;
                @(negedge clk);
                ret_valid_i = 1'b0;
            end else if (wr_req_o) begin
                repeat (rand_below(5)) @(negedge clk);
                mem[wr_addr_o] = wr_data_o;
                wr_rdy_i = 1'b1;
                @(negedge clk);
                wr_rdy_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin : stimulus
        logic [`ADDR_SIZE-1:0] addr;
        reset       = 1'b1;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_wstrb_i = '0;
        req_wdata_i = '0;
        rd_rdy_i    = 1'b0;
        ret_valid_i = 1'b0;
        ret_data_i  = '0;
        wr_rdy_i    = 1'b0;
        test_end    = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // first touch misses, second hits
        for (int i = 0; i < 4; i++) begin
            addr = 32'h0000_1000 + `ADDR_SIZE'(i * 36);
            cpu_access(1'b0, addr, '0, '0);
            cpu_access(1'b0, addr, '0, '0);
        end
        finish_test();

        // partial strobes, hit and miss
        cpu_access(1'b1, 32'h0000_1008, 4'b0101, 32'haabb_ccdd);
        cpu_access(1'b0, 32'h0000_1008, '0, '0);
        cpu_access(1'b1, 32'h0000_1008, 4'b1000, 32'h1122_3344);
        cpu_access(1'b0, 32'h0000_1008, '0, '0);
        cpu_access(1'b1, 32'h0002_4004, 4'b0011, 32'h5566_7788);
        cpu_access(1'b0, 32'h0002_4004, '0, '0);
        cpu_access(1'b0, 32'h0000_1008, '0, '0);
        finish_test();

        // three lines in set 9, dirty one gets evicted
        cpu_access(1'b1, 32'h0001_0120, 4'b1111, 32'hdead_beef);
        cpu_access(1'b0, 32'h0001_1120, '0, '0);
        cpu_access(1'b0, 32'h0001_2120, '0, '0);
        cpu_access(1'b0, 32'h0001_0120, '0, '0);
        cpu_access(1'b0, 32'h0001_2120, '0, '0);
        finish_test();

        random_burst(80, 4, 16, 4);
        finish_test();

        random_burst(40, 3, 40, 1);   // one hot set, many writebacks
        finish_test();

        $display("done: %0d tests run, %0d failed, %0d errors", tests, failed, errors);
        if (tests == NUM_TESTS && failed == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- bench/dcache_checker.sv
`include "dcache_settings.svh"

module dcache_checker
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid_i,
    input  logic                  req_write_i,
    input  logic [`ADDR_SIZE-1:0] req_addr_i,
    input  logic [`STRB_SIZE-1:0] req_wstrb_i,
    input  word_t                 req_wdata_i,
    input  logic                  addr_ok_i,
    input  logic                  data_ok_i,
    input  word_t                 rdata_i,
    input  logic                  cache_miss_i,
    input  logic                  rd_req_i,
    input  logic [`ADDR_SIZE-1:0] rd_addr_i,
    input  logic                  rd_rdy_i,
    input  logic                  wr_req_i,
    input  logic [`ADDR_SIZE-1:0] wr_addr_i,
    input  line_t                 wr_data_i,
    input  logic                  wr_rdy_i,
    input  logic                  test_end_i,
    output logic                  idle_o,
    output int                    tests_o,
    output int                    failed_o,
    output int                    errors_o
);

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic                  write;
        logic [`ADDR_SIZE-1:0] addr;
        word_t                 exp;
        logic                  miss;
        logic                  wb;
        logic [`ADDR_SIZE-1:0] wb_addr;
    } pend_rec_t;

    word_t                 shadow [int unsigned];    // keyed by word address
    pend_rec_t             pend [$];
    logic [`TAG_SIZE-1:0]  m_tag [`SET_NUM][`WAY_NUM];
    logic                  m_valid [`SET_NUM][`WAY_NUM];
    logic                  m_dirty [`SET_NUM][`WAY_NUM];
    logic                  m_lru [`SET_NUM];
    logic                  miss_seen;
    logic                  wb_seen;
    logic                  rd_wait;
    logic                  wr_wait;
    logic [`ADDR_SIZE-1:0] rd_addr_q;
    logic [`ADDR_SIZE-1:0] wr_addr_q;
    line_t                 wr_data_q;
    pend_rec_t             rec;
    int                    tests = 0;
    int                    failed = 0;
    int                    errors = 0;
    int                    test_errs = 0;

    assign tests_o  = tests;
    assign failed_o = failed;
    assign errors_o = errors;

    function automatic word_t initial_word(input logic [`ADDR_SIZE-1:0] addr);
        return {~addr[15:0], addr[31:16]} ^ 32'h1357_9bdf;
    endfunction

    function automatic word_t apply_strobes(input word_t old_w, input word_t new_w,
                                            input logic [`STRB_SIZE-1:0] strb);
        word_t res;
        for (int b = 0; b < `STRB_SIZE; b++) begin
            res[8*b +: 8] = strb[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return res;
    endfunction

    // reference: the word that memory plus all accepted writes hold
    function automatic word_t expected_word(input logic [`ADDR_SIZE-1:0] addr);
        if (shadow.exists(addr >> 2)) begin
            return shadow[addr >> 2];
        end
        return initial_word({addr[`ADDR_SIZE-1:2], 2'b00});
    endfunction

    task automatic count_error();
        errors++;
        test_errs++;
    endtask

    task automatic value_mismatch(input string msg);
        $display("ERR %0t: %s", $time, msg);
        count_error();
    endtask

    task automatic protocol_error(input string msg);
        $display("protocol error at %0t: %s", $time, msg);
        count_error();
    endtask

    // predicts hit, victim and writeback from the set model
    task automatic accept_request();
        logic [`INDEX_SIZE-1:0] idx;
        logic [`TAG_SIZE-1:0]   tag;
        logic                   way;
        logic                   hit;
        pend_rec_t              r;
        idx = req_addr_i[`INDEX_LOC];
        tag = req_addr_i[`TAG_LOC];
        hit = 1'b0;
        way = m_lru[idx];
        r = '0;
        r.write = req_write_i;
        r.addr = req_addr_i;
        for (int w = 0; w < `WAY_NUM; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (!hit) begin
            r.miss = 1'b1;
            if (m_valid[idx][way] && m_dirty[idx][way]) begin
                r.wb = 1'b1;
                r.wb_addr = {m_tag[idx][way], idx, `OFFSET_SIZE'(0)};
            end
            m_valid[idx][way] = 1'b1;
            m_tag[idx][way] = tag;
            m_dirty[idx][way] = 1'b0;
        end
        if (req_write_i) begin
            m_dirty[idx][way] = 1'b1;
            shadow[req_addr_i >> 2] = apply_strobes(expected_word(req_addr_i),
                                                    req_wdata_i, req_wstrb_i);
        end else begin
            r.exp = expected_word(req_addr_i);
        end
        m_lru[idx] = ~way;
        pend.push_back(r);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            pend.delete();
            for (int s = 0; s < `SET_NUM; s++) begin
                m_lru[s] = 1'b0;
                for (int w = 0; w < `WAY_NUM; w++) begin
                    m_valid[s][w] = 1'b0;
                    m_dirty[s][w] = 1'b0;
                    m_tag[s][w] = '0;
                end
            end
            miss_seen = 1'b0;
            wb_seen = 1'b0;
            rd_wait = 1'b0;
            wr_wait = 1'b0;
        end else begin
            if (cache_miss_i) begin
                if (pend.size() == 0 || !pend[0].miss) begin
                    protocol_error("cache_miss_o raised for a request that should hit");
                end
                miss_seen = 1'b1;
            end
            if (rd_req_i && rd_rdy_i) begin
                if (pend.size() == 0 || !pend[0].miss ||
                    rd_addr_i != {pend[0].addr[`ADDR_SIZE-1:`OFFSET_SIZE],
                                  `OFFSET_SIZE'(0)}) begin
                    value_mismatch($sformatf("unexpected line read from %h", rd_addr_i));
                end
            end
            if (wr_req_i && wr_rdy_i) begin
                if (pend.size() == 0 || !pend[0].wb || wr_addr_i != pend[0].wb_addr) begin
                    value_mismatch($sformatf("unexpected writeback to %h", wr_addr_i));
                end
                for (int i = 0; i < `BANK_NUM; i++) begin
                    if (wr_data_i[i] != expected_word(wr_addr_i + `ADDR_SIZE'(4 * i))) begin
                        value_mismatch($sformatf("writeback word %0d of %h is %h, expected %h",
                            i, wr_addr_i, wr_data_i[i],
                            expected_word(wr_addr_i + `ADDR_SIZE'(4 * i))));
                    end
                end
                wb_seen = 1'b1;
            end
            if (data_ok_i) begin
                if (pend.size() == 0) begin
                    protocol_error("data_ok_o with no request outstanding");
                end else begin
                    rec = pend.pop_front();
                    if (!rec.write && rdata_i != rec.exp) begin
                        value_mismatch($sformatf("read %h returned %h, expected %h",
                            rec.addr, rdata_i, rec.exp));
                    end
                    if (rec.miss != miss_seen) begin
                        value_mismatch($sformatf("access %h miss flag %b, expected %b",
                            rec.addr, miss_seen, rec.miss));
                    end
                    if (rec.wb != wb_seen) begin
                        protocol_error($sformatf("missing writeback before refill of %h",
                            rec.addr));
                    end
                end
                miss_seen = 1'b0;
                wb_seen = 1'b0;
            end
            if (req_valid_i && addr_ok_i) begin
                accept_request();
            end
            if (rd_wait && (!rd_req_i || rd_addr_i != rd_addr_q)) begin
                protocol_error("rd_req_o dropped or changed before rd_rdy_i");
            end
            if (wr_wait && (!wr_req_i || wr_addr_i != wr_addr_q || wr_data_i != wr_data_q)) begin
                protocol_error("wr_req_o dropped or changed before wr_rdy_i");
            end
            rd_wait = rd_req_i && !rd_rdy_i;
            wr_wait = wr_req_i && !wr_rdy_i;
            rd_addr_q = rd_addr_i;
            wr_addr_q = wr_addr_i;
            wr_data_q = wr_data_i;
            if (test_end_i) begin
                tests++;
                if (test_errs != 0) begin
                    failed++;
                end
                $display("test %0d finished with %0d errors", tests, test_errs);
                test_errs = 0;
            end
        end
        idle_o <= pend.size() == 0;
    end

endmodule

//--- verilog/dcache_top.sv
`include "dcache_settings.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid_i,
    input  logic                  req_write_i,
    input  logic [`ADDR_SIZE-1:0] req_addr_i,
    input  logic [`STRB_SIZE-1:0] req_wstrb_i,
    input  word_t                 req_wdata_i,
    output logic                  addr_ok_o,
    output logic                  data_ok_o,
    output word_t                 rdata_o,
    output logic                  cache_miss_o,
    output logic                  rd_req_o,
    output logic [`ADDR_SIZE-1:0] rd_addr_o,
    input  logic                  rd_rdy_i,
    input  logic                  ret_valid_i,
    input  line_t                 ret_data_i,
    output logic                  wr_req_o,
    output logic [`ADDR_SIZE-1:0] wr_addr_o,
    output line_t                 wr_data_o,
    input  logic                  wr_rdy_i
);

    logic                               ram_en;
    logic [`INDEX_SIZE-1:0]             ram_addr;
    logic [`WAY_NUM-1:0][`BANK_NUM-1:0] data_we;
    word_t [`BANK_NUM-1:0]              data_wdata;
    logic [`WAY_NUM-1:0]                tag_we;
    tagv_t                              tag_wdata;
    word_t [`WAY_NUM-1:0][`BANK_NUM-1:0] bank_rdata;
    tagv_t [`WAY_NUM-1:0]               tagv_rdata;
    logic                               hit;
    logic                               hit_way;
    logic                               victim_way;
    line_t                              victim_line;
    logic [`TAG_SIZE-1:0]               victim_tag;
    logic [`TAG_SIZE-1:0]               look_tag;
    logic [`WORD_OFF_SIZE-1:0]          look_offset;
    word_t                              read_word;

    assign ram_en  = ~reset;    // rams idle while in reset
    assign rdata_o = read_word;

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .req_valid_i   (req_valid_i),
        .req_write_i   (req_write_i),
        .req_addr_i    (req_addr_i),
        .req_wstrb_i   (req_wstrb_i),
        .req_wdata_i   (req_wdata_i),
        .addr_ok_o     (addr_ok_o),
        .data_ok_o     (data_ok_o),
        .cache_miss_o  (cache_miss_o),
        .hit_i         (hit),
        .hit_way_i     (hit_way),
        .victim_line_i (victim_line),
        .victim_tag_i  (victim_tag),
        .bank_word_i   (read_word),
        .victim_way_o  (victim_way),
        .rd_req_o      (rd_req_o),
        .rd_addr_o     (rd_addr_o),
        .rd_rdy_i      (rd_rdy_i),
        .ret_valid_i   (ret_valid_i),
        .ret_data_i    (ret_data_i),
        .wr_req_o      (wr_req_o),
        .wr_addr_o     (wr_addr_o),
        .wr_data_o     (wr_data_o),
        .wr_rdy_i      (wr_rdy_i),
        .ram_addr_o    (ram_addr),
        .data_we_o     (data_we),
        .data_wdata_o  (data_wdata),
        .tag_we_o      (tag_we),
        .tag_wdata_o   (tag_wdata),
        .look_tag_o    (look_tag),
        .look_offset_o (look_offset)
    );

    for (genvar w = 0; w < `WAY_NUM; w++) begin : g_way
        for (genvar b = 0; b < `BANK_NUM; b++) begin : g_bank
            sync_ram #(
                .payload_t (word_t),
                .DEPTH     (`SET_NUM)
            ) u_data (
                .clk     (clk),
                .en_i    (ram_en),
                .we_i    (data_we[w][b]),
                .addr_i  (ram_addr),
                .wdata_i (data_wdata[b]),
                .rdata_o (bank_rdata[w][b])
            );
        end

        sync_ram #(
            .payload_t (tagv_t),
            .DEPTH     (`SET_NUM)
        ) u_tagv (
            .clk     (clk),
            .en_i    (ram_en),
            .we_i    (tag_we[w]),
            .addr_i  (ram_addr),
            .wdata_i (tag_wdata),
            .rdata_o (tagv_rdata[w])
        );
    end

    way_select u_way_select (
        .bank_rdata_i  (bank_rdata),
        .tagv_i        (tagv_rdata),
        .look_tag_i    (look_tag),
        .look_offset_i (look_offset),
        .victim_way_i  (victim_way),
        .hit_o         (hit),
        .hit_way_o     (hit_way),
        .rdata_o       (read_word),
        .victim_line_o (victim_line),
        .victim_tag_o  (victim_tag)
    );

endmodule

//--- verilog/way_select.sv
`include "dcache_settings.svh"

module way_select
    import dcache_pkg::*;
(
    input  word_t [`WAY_NUM-1:0][`BANK_NUM-1:0] bank_rdata_i,
    input  tagv_t [`WAY_NUM-1:0]                tagv_i,
    input  logic [`TAG_SIZE-1:0]                look_tag_i,
    input  logic [`WORD_OFF_SIZE-1:0]           look_offset_i,
    input  logic                                victim_way_i,
    output logic                                hit_o,
    output logic                                hit_way_o,
    output word_t                               rdata_o,
    output line_t                               victim_line_o,
    output logic [`TAG_SIZE-1:0]                victim_tag_o
);

    logic [`WAY_NUM-1:0] way_hit;

    always_comb begin
        for (int w = 0; w < `WAY_NUM; w++) begin
            way_hit[w] = tagv_i[w].valid && tagv_i[w].tag == look_tag_i;
        end
    end

    // at most one way matches, so the encoder needs no priority
    always_comb begin
        hit_way_o = 1'b0;
        for (int w = 1; w < `WAY_NUM; w++) begin
            if (way_hit[w]) begin
                hit_way_o = 1'b1;
            end
        end
    end

    assign hit_o   = |way_hit;
    assign rdata_o = bank_rdata_i[hit_way_o][look_offset_i];

    // line and tag of the way picked for eviction
    assign victim_line_o = bank_rdata_i[victim_way_i];
    assign victim_tag_o  = tagv_i[victim_way_i].tag;

endmodule

//--- verilog/dcache_ctrl.sv
`include "dcache_settings.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req_valid_i,
    input  logic                               req_write_i,
    input  logic [`ADDR_SIZE-1:0]              req_addr_i,
    input  logic [`STRB_SIZE-1:0]              req_wstrb_i,
    input  word_t                              req_wdata_i,
    output logic                               addr_ok_o,
    output logic                               data_ok_o,
    output logic                               cache_miss_o,
    input  logic                               hit_i,
    input  logic                               hit_way_i,
    input  line_t                              victim_line_i,
    input  logic [`TAG_SIZE-1:0]               victim_tag_i,
    input  word_t                              bank_word_i,
    output logic                               victim_way_o,
    output logic                               rd_req_o,
    output logic [`ADDR_SIZE-1:0]              rd_addr_o,
    input  logic                               rd_rdy_i,
    input  logic                               ret_valid_i,
    input  line_t                              ret_data_i,
    output logic                               wr_req_o,
    output logic [`ADDR_SIZE-1:0]              wr_addr_o,
    output line_t                              wr_data_o,
    input  logic                               wr_rdy_i,
    output logic [`INDEX_SIZE-1:0]             ram_addr_o,
    output logic [`WAY_NUM-1:0][`BANK_NUM-1:0] data_we_o,
    output word_t [`BANK_NUM-1:0]              data_wdata_o,
    output logic [`WAY_NUM-1:0]                tag_we_o,
    output tagv_t                              tag_wdata_o,
    output logic [`TAG_SIZE-1:0]               look_tag_o,
    output logic [`WORD_OFF_SIZE-1:0]          look_offset_o
);

    ctrl_state_e               state;
    logic                      look_valid;
    logic                      look_write;
    logic [`ADDR_SIZE-1:0]     look_addr;
    logic [`STRB_SIZE-1:0]     look_wstrb;
    word_t                     look_wdata;
    logic [`INDEX_SIZE-1:0]    look_index;
    logic                      rd_sent;
    logic                      sweeping;
    logic [`INDEX_SIZE-1:0]    sweep_idx;
    line_t                     fill_line;
    logic [`SET_NUM-1:0]       lru;      // points at the way to evict
    logic [`WAY_NUM-1:0]       dirty [`SET_NUM];
    logic                      accept;
    logic                      lookup_hit;
    logic                      lookup_miss;
    word_t                     merged_word;

    function automatic word_t merge_word(word_t old_w, word_t new_w,
                                         logic [`STRB_SIZE-1:0] strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < `STRB_SIZE; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign look_index    = look_addr[`INDEX_LOC];
    assign look_tag_o    = look_addr[`TAG_LOC];
    assign look_offset_o = look_addr[`WORD_LOC];
    assign victim_way_o  = lru[look_index];
    assign merged_word   = merge_word(bank_word_i, look_wdata, look_wstrb);

    assign lookup_hit  = state == IDLE_LOOKUP && look_valid && hit_i;
    assign lookup_miss = state == IDLE_LOOKUP && look_valid && !hit_i;

    // a write hit owns the ram port during its lookup
    assign addr_ok_o    = !sweeping && state == IDLE_LOOKUP &&
                          !(look_valid && (look_write || !hit_i));
    assign accept       = req_valid_i && addr_ok_o;
    assign data_ok_o    = lookup_hit;
    assign cache_miss_o = lookup_miss;

    assign rd_req_o  = state == REFILL && !rd_sent;
    assign rd_addr_o = {look_addr[`TAG_LOC], look_index, {`OFFSET_SIZE{1'b0}}};
    assign wr_req_o  = state == WRITEBACK;
    assign wr_addr_o = {victim_tag_i, look_index, {`OFFSET_SIZE{1'b0}}};
    assign wr_data_o = victim_line_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            look_valid <= 1'b0;
        end else if (accept) begin
            look_valid <= 1'b1;
        end else if (lookup_hit) begin
            look_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            look_write <= req_write_i;
            look_addr  <= req_addr_i;
            look_wstrb <= req_wstrb_i;
            look_wdata <= req_wdata_i;
        end
    end

    // miss sequence, the refilled request looks up again as a hit
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE_LOOKUP;
            rd_sent <= 1'b0;
        end else begin
            case (state)
                IDLE_LOOKUP: begin
                    if (lookup_miss) begin
                        state <= dirty[look_index][victim_way_o] ? WRITEBACK : REFILL;
                    end
                end
                WRITEBACK: begin
                    if (wr_rdy_i) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (rd_req_o && rd_rdy_i) begin
                        rd_sent <= 1'b1;
                    end
                    if (ret_valid_i) begin
                        state   <= FILL_WRITE;
                        rd_sent <= 1'b0;
                    end
                end
                default: state <= IDLE_LOOKUP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sweeping  <= 1'b1;
            sweep_idx <= '0;
        end else if (sweeping) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == `INDEX_SIZE'(`SET_NUM - 1)) begin
                sweeping <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == REFILL && ret_valid_i) begin
            for (int i = 0; i < `BANK_NUM; i++) begin
                if (look_write && i == int'(look_offset_o)) begin
                    fill_line[i] <= merge_word(ret_data_i[i], look_wdata, look_wstrb);
                end else begin
                    fill_line[i] <= ret_data_i[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sweeping) begin
            lru[sweep_idx]   <= 1'b0;
            dirty[sweep_idx] <= '0;
        end else if (lookup_hit) begin
            lru[look_index] <= ~hit_way_i;
            if (look_write) begin
                dirty[look_index][hit_way_i] <= 1'b1;
            end
        end else if (state == FILL_WRITE) begin
            dirty[look_index][victim_way_o] <= look_write;
        end
    end

    assign ram_addr_o = sweeping ? sweep_idx :
                        accept   ? req_addr_i[`INDEX_LOC] : look_index;

    always_comb begin
        data_we_o         = '0;
        tag_we_o          = '0;
        tag_wdata_o.valid = 1'b1;
        tag_wdata_o.tag   = look_addr[`TAG_LOC];
        for (int b = 0; b < `BANK_NUM; b++) begin
            data_wdata_o[b] = (state == FILL_WRITE) ? fill_line[b] : merged_word;
        end
        if (sweeping) begin
            tag_we_o    = '1;
            tag_wdata_o = '0;   // invalid entry
        end else if (state == FILL_WRITE) begin
            data_we_o[victim_way_o] = '1;
            tag_we_o[victim_way_o]  = 1'b1;
        end else if (lookup_hit && look_write) begin
            data_we_o[hit_way_i][look_offset_o] = 1'b1;
        end
    end

    a_rd_req_hold: assert property (@(posedge clk) disable iff (reset)
        rd_req_o && !rd_rdy_i |=> rd_req_o && $stable(rd_addr_o))
        else $error("dcache_ctrl: rd_req dropped or moved before rd_rdy");

    a_ret_in_refill: assert property (@(posedge clk) disable iff (reset)
        ret_valid_i |-> state == REFILL)
        else $error("dcache_ctrl: ret_valid outside of refill");

endmodule

//--- verilog/sync_ram.sv
`include "dcache_settings.svh"

module sync_ram
    import dcache_pkg::*;
#(
    parameter type payload_t = word_t,
    parameter int  DEPTH     = `SET_NUM
) (
    input  logic                     clk,
    input  logic                     en_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  payload_t                 wdata_i,
    output payload_t                 rdata_o
);

    payload_t mem [DEPTH];

    // write-first, output holds while en_i is low
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
                rdata_o     <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

    a_addr_known: assert property (@(posedge clk) en_i |-> !$isunknown(addr_i))
        else $error("sync_ram: unknown address while enabled");

endmodule

//--- verilog/dcache_pkg.sv
`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [`DATA_SIZE-1:0] word_t;

    typedef word_t [`BANK_NUM-1:0] line_t;   // word 0 sits in the low bits

    // payload of the tag rams
    typedef struct packed {
        logic                 valid;
        logic [`TAG_SIZE-1:0] tag;
    } tagv_t;

    typedef enum logic [1:0] {
        IDLE_LOOKUP,
        WRITEBACK,
        REFILL,
        FILL_WRITE
    } ctrl_state_e;

endpackage

//--- verilog/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// address split
`define ADDR_SIZE   32
`define DATA_SIZE   32
`define TAG_SIZE    20
`define INDEX_SIZE  7
`define OFFSET_SIZE 5

// geometry
`define BANK_NUM    8
`define SET_NUM     128
`define WAY_NUM     2

`define STRB_SIZE     (`DATA_SIZE / 8)
`define WORD_OFF_SIZE (`OFFSET_SIZE - 2)    // word select inside a line

// field positions in a byte address
`define TAG_LOC   `ADDR_SIZE-1:`ADDR_SIZE-`TAG_SIZE
`define INDEX_LOC `OFFSET_SIZE+`INDEX_SIZE-1:`OFFSET_SIZE
`define WORD_LOC  `OFFSET_SIZE-1:2

`endif
